// File: Makefile
TOP = tb_keypad_calc

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f sources.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: logic/calc_controller.sv
`default_nettype none

module calc_controller
    import calc_pkg::*;
(
    input  logic clk,
    input  logic nRST,
    key_event_if.sink evt,
    output logic load_digit,
    output logic set_op,
    output logic do_neg,
    output logic do_eval,
    output logic clear_entry,
    output logic select_b,                      // b is the working operand
    output op_t  op_sel
);

    calc_state_t state, state_nx;
    logic        ready_q;
    logic        new_key;
    logic        load_nx;
    logic        set_nx;
    logic        neg_nx;
    logic        eval_nx;
    logic        clear_nx;

    // act on the first cycle of ready only
    assign new_key = evt.ready && !ready_q;

    always_comb begin
        state_nx = state;
        load_nx  = 1'b0;
        set_nx   = 1'b0;
        neg_nx   = 1'b0;
        eval_nx  = 1'b0;
        clear_nx = 1'b0;
        if (new_key) begin
            if (evt.is_digit) begin
                load_nx = 1'b1;
                if (state == SHOW) begin
                    clear_nx = 1'b1;            // fresh operand after a result
                    state_nx = ENTER_A;
                end
            end else if (evt.is_equal) begin
                if (state == ENTER_B) begin
                    eval_nx  = 1'b1;
                    state_nx = SHOW;
                end
            end else if (evt.op == OP_NEG) begin
                neg_nx = 1'b1;
            end else if (evt.op != OP_NONE) begin
                if (state != ENTER_B) begin
                    set_nx   = 1'b1;
                    clear_nx = 1'b1;            // clears b, selected below
                    state_nx = ENTER_B;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state       <= ENTER_A;
            ready_q     <= 1'b0;
            evt.ack     <= 1'b0;
            load_digit  <= 1'b0;
            set_op      <= 1'b0;
            do_neg      <= 1'b0;
            do_eval     <= 1'b0;
            clear_entry <= 1'b0;
            select_b    <= 1'b0;
        end else begin
            state       <= state_nx;
            ready_q     <= evt.ready;
            evt.ack     <= new_key;             // one pulse per key, # included
            load_digit  <= load_nx;
            set_op      <= set_nx;
            do_neg      <= neg_nx;
            do_eval     <= eval_nx;
            clear_entry <= clear_nx;
            select_b    <= (state_nx == ENTER_B);
        end
    end

    always_ff @(posedge clk) begin
        if (set_nx)
            op_sel <= evt.op;
    end

endmodule

`default_nettype wire

// File: logic/calc_datapath.sv
`default_nettype none

module calc_datapath
    import calc_pkg::*;
(
    input  logic                     clk,
    input  logic                     nRST,
    input  logic                     load_digit,
    input  logic [3:0]               digit,
    input  logic                     set_op,
    input  op_t                      op_sel,
    input  logic                     do_neg,
    input  logic                     do_eval,
    input  logic                     clear_entry,
    input  logic                     select_b,
    output logic signed [DATA_W-1:0] display_value,
    output logic                     result_valid
);

    logic signed [DATA_W-1:0] a, b;
    logic signed [DATA_W-1:0] a_nx, b_nx;
    logic signed [DATA_W-1:0] base;
    logic signed [DATA_W-1:0] entry;
    logic signed [DATA_W-1:0] result;
    op_t                      op_q;

    // working operand update
    always_comb begin
        base  = clear_entry ? '0 : (select_b ? b : a);
        entry = base;
        if (load_digit)
            entry = DATA_W'(base * 10) + DATA_W'(digit);    // wraps mod 2^16
        else if (do_neg)
            entry = -base;
    end

    // arithmetic unit
    always_comb begin
        case (op_q)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_MUL:  result = DATA_W'(a * b);   // low half of the product
            default: result = a;
        endcase
    end

    always_comb begin
        a_nx = a;
        b_nx = b;
        if (do_eval)
            a_nx = result;
        else if (select_b)
            b_nx = entry;
        else
            a_nx = entry;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            a             <= '0;
            b             <= '0;
            display_value <= '0;
            result_valid  <= 1'b0;
        end else begin
            a             <= a_nx;
            b             <= b_nx;
            display_value <= select_b ? b_nx : a_nx;
            result_valid  <= do_eval;
        end
    end

    always_ff @(posedge clk) begin
        if (set_op)
            op_q <= op_sel;
    end

endmodule

`default_nettype wire

// File: logic/calc_pkg.sv
`default_nettype none

package calc_pkg;

    localparam int DATA_W = 16;                 // operand and result width
    localparam int DEBOUNCE_CYCLES = 10;        // cycles a row must stay high
    localparam int DEB_W = 4;                   // debounce counter width

    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    typedef enum logic [1:0] {
        ENTER_A,                                // building first operand
        ENTER_B,                                // building second operand
        SHOW                                    // result on display
    } calc_state_t;

    // key codes, row * 4 + column
    localparam logic [3:0] KEY_ADD   = 4'd3;
    localparam logic [3:0] KEY_SUB   = 4'd7;
    localparam logic [3:0] KEY_MUL   = 4'd11;
    localparam logic [3:0] KEY_EQUAL = 4'd12;
    localparam logic [3:0] KEY_HASH  = 4'd14;
    localparam logic [3:0] KEY_NEG   = 4'd15;

    // key code for each decimal digit, indexed by the digit
    localparam logic [3:0] KEY_OF_DIGIT [10] = '{
        4'd13, 4'd0, 4'd1, 4'd2,
        4'd4,  4'd5, 4'd6,
        4'd8,  4'd9, 4'd10
    };

endpackage

`default_nettype wire

// File: logic/debounce_timer.sv
`default_nettype none

module debounce_timer
    import calc_pkg::*;
(
    input  logic clk,
    input  logic nRST,
    input  logic timer_run,
    input  logic row_active,
    output logic stable_done
);

    localparam logic [DEB_W-1:0] LIMIT = DEB_W'(DEBOUNCE_CYCLES);

    logic [DEB_W-1:0] count;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (!timer_run || !row_active) begin
            count <= '0;                        // any gap restarts the interval
        end else if (count != LIMIT) begin
            count <= count + 1'b1;              // saturates at the limit
        end
    end

    assign stable_done = (count == LIMIT);

endmodule

`default_nettype wire

// File: logic/key_decoder.sv
`default_nettype none

module key_decoder
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic       key_strobe,
    input  logic [3:0] key_code,
    input  logic       key_done,
    key_event_if.source evt
);

    logic       dec_is_digit;
    logic [3:0] dec_digit;
    op_t        dec_op;
    logic       dec_is_equal;

    always_comb begin
        dec_is_digit = 1'b0;
        dec_digit    = 4'd0;
        dec_op       = OP_NONE;
        dec_is_equal = 1'b0;
        case (key_code)
            4'h0: begin dec_is_digit = 1'b1; dec_digit = 4'd1; end
            4'h1: begin dec_is_digit = 1'b1; dec_digit = 4'd2; end
            4'h2: begin dec_is_digit = 1'b1; dec_digit = 4'd3; end
            4'h3: dec_op = OP_ADD;              // A
            4'h4: begin dec_is_digit = 1'b1; dec_digit = 4'd4; end
            4'h5: begin dec_is_digit = 1'b1; dec_digit = 4'd5; end
            4'h6: begin dec_is_digit = 1'b1; dec_digit = 4'd6; end
            4'h7: dec_op = OP_SUB;              // B
            4'h8: begin dec_is_digit = 1'b1; dec_digit = 4'd7; end
            4'h9: begin dec_is_digit = 1'b1; dec_digit = 4'd8; end
            4'hA: begin dec_is_digit = 1'b1; dec_digit = 4'd9; end
            4'hB: dec_op = OP_MUL;              // C
            4'hC: dec_is_equal = 1'b1;          // * key
            4'hD: begin dec_is_digit = 1'b1; dec_digit = 4'd0; end
            4'hF: dec_op = OP_NEG;              // D
            default: ;                          // # carries no class
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            evt.ready <= 1'b0;
        else if (key_strobe)
            evt.ready <= 1'b1;
        else if (key_done)
            evt.ready <= 1'b0;                  // dropped once key is released
    end

    always_ff @(posedge clk) begin
        if (key_strobe) begin
            evt.is_digit <= dec_is_digit;
            evt.digit    <= dec_digit;
            evt.op       <= dec_op;
            evt.is_equal <= dec_is_equal;
        end
    end

endmodule

`default_nettype wire

// File: logic/key_event_if.sv
`default_nettype none

interface key_event_if
    import calc_pkg::*;
();
    logic       ready;                          // decoded key waiting
    logic       ack;                            // controller took the key
    logic       is_digit;
    logic [3:0] digit;
    op_t        op;
    logic       is_equal;

    modport source (output ready, output is_digit, output digit,
                    output op, output is_equal, input ack);

    modport sink (input ready, input is_digit, input digit,
                  input op, input is_equal, output ack);

endinterface

`default_nettype wire

// File: logic/keypad_calc_top.sv
`default_nettype none

module keypad_calc_top
    import calc_pkg::*;
(
    input  logic                     clk,
    input  logic                     nRST,
    input  logic [3:0]               row_in,
    output logic [3:0]               col_out,
    output logic signed [DATA_W-1:0] display_value,
    output logic                     result_valid
);

    logic       row_active;
    logic       timer_run;
    logic       stable_done;
    logic       key_strobe;
    logic [3:0] key_code;
    logic       key_done;
    logic       load_digit;
    logic       set_op;
    logic       do_neg;
    logic       do_eval;
    logic       clear_entry;
    logic       select_b;
    op_t        op_sel;

    key_event_if evt_if ();

    keypad_scan_fsm u_scan (
        .clk            (clk),
        .nRST           (nRST),
        .row_in         (row_in),
        .stable_done    (stable_done),
        .key_ack        (evt_if.ack),
        .key_done_clear (evt_if.ready),
        .col_out        (col_out),
        .row_active     (row_active),
        .timer_run      (timer_run),
        .key_strobe     (key_strobe),
        .key_code       (key_code),
        .key_done       (key_done)
    );

    debounce_timer u_timer (
        .clk         (clk),
        .nRST        (nRST),
        .timer_run   (timer_run),
        .row_active  (row_active),
        .stable_done (stable_done)
    );

    key_decoder u_decoder (
        .clk        (clk),
        .nRST       (nRST),
        .key_strobe (key_strobe),
        .key_code   (key_code),
        .key_done   (key_done),
        .evt        (evt_if.source)
    );

    calc_controller u_ctrl (
        .clk         (clk),
        .nRST        (nRST),
        .evt         (evt_if.sink),
        .load_digit  (load_digit),
        .set_op      (set_op),
        .do_neg      (do_neg),
        .do_eval     (do_eval),
        .clear_entry (clear_entry),
        .select_b    (select_b),
        .op_sel      (op_sel)
    );

    calc_datapath u_datapath (
        .clk           (clk),
        .nRST          (nRST),
        .load_digit    (load_digit),
        .digit         (evt_if.digit),
        .set_op        (set_op),
        .op_sel        (op_sel),
        .do_neg        (do_neg),
        .do_eval       (do_eval),
        .clear_entry   (clear_entry),
        .select_b      (select_b),
        .display_value (display_value),
        .result_valid  (result_valid)
    );

endmodule

`default_nettype wire

// File: logic/keypad_scan_fsm.sv
`default_nettype none

module keypad_scan_fsm (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row_in,                  // high while a key is pressed
    input  logic       stable_done,
    input  logic       key_ack,
    input  logic       key_done_clear,          // decoder still holds a key
    output logic [3:0] col_out,
    output logic       row_active,
    output logic       timer_run,
    output logic       key_strobe,
    output logic [3:0] key_code,
    output logic       key_done
);

    typedef enum logic [2:0] {
        IDLE,
        SCAN,
        WAIT_STABLE,
        CONFIRM,
        WAIT_RELEASE
    } scan_state_t;

    scan_state_t state, state_nx;
    logic [1:0]  col_index;
    logic [1:0]  row_index;
    logic        enter_confirm;
    logic        leave_release;

    assign row_active = |row_in;
    assign timer_run  = (state == WAIT_STABLE);

    assign enter_confirm = (state == WAIT_STABLE) && (state_nx == CONFIRM);
    assign leave_release = (state == WAIT_RELEASE) && (state_nx != WAIT_RELEASE);

    always_comb begin
        col_out = 4'b0001 << col_index;
    end

    // lowest active row wins
    always_comb begin
        casez (row_in)
            4'b???1: row_index = 2'd0;
            4'b??10: row_index = 2'd1;
            4'b?100: row_index = 2'd2;
            default: row_index = 2'd3;
        endcase
    end

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:         state_nx = SCAN;
            SCAN:         state_nx = row_active ? WAIT_STABLE : SCAN;
            WAIT_STABLE: begin
                if (!row_active)
                    state_nx = SCAN;            // bounce or glitch, resume scan
                else if (stable_done)
                    state_nx = CONFIRM;
            end
            CONFIRM:      state_nx = key_ack ? WAIT_RELEASE : CONFIRM;
            WAIT_RELEASE: state_nx = row_active ? WAIT_RELEASE : SCAN;
            default:      state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            col_index  <= 2'd0;
            key_strobe <= 1'b0;
            key_done   <= 1'b0;
        end else begin
            state      <= state_nx;
            key_strobe <= enter_confirm;
            key_done   <= leave_release && key_done_clear;
            if (state == SCAN && !row_active)
                col_index <= col_index + 2'd1;  // freeze on a hit
        end
    end

    always_ff @(posedge clk) begin
        if (enter_confirm)
            key_code <= {row_index, col_index};
    end

endmodule

`default_nettype wire

// File: sources.f
logic/calc_pkg.sv
logic/key_event_if.sv
logic/keypad_scan_fsm.sv
logic/debounce_timer.sv
logic/key_decoder.sv
logic/calc_controller.sv
logic/calc_datapath.sv
logic/keypad_calc_top.sv
verif/tb_clock_gen.sv
verif/tb_keypad_calc.sv

// File: verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 5;            // 10 ns period
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 nRST = 1'b1;                         // release just after an edge
    end

endmodule

`default_nettype wire

// File: verif/tb_keypad_calc.sv
`default_nettype none

module tb_keypad_calc
    import calc_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HOLD_CYCLES    = 40;
    localparam int RELEASE_CYCLES = 20;
    localparam int GLITCH_CYCLES  = 4;
    localparam int CHECK_DELAY    = 10;         // after release
    localparam int MAX_KEYS       = 258;        // tests 2 to 6, glitch included
    localparam int CYCLE_LIMIT    = MAX_KEYS * 70 + 200;

    logic                     clk;
    logic                     nRST;
    logic [3:0]               row_in;
    logic [3:0]               col_out;
    logic signed [DATA_W-1:0] display_value;
    logic                     result_valid;

    logic       key_held;
    logic [3:0] held_code;
    logic [3:0] key_hist [MAX_KEYS];            // every accepted press so far
    int         hist_len;
    logic [31:0] lcg_state;
    int         errors;
    int         checks;
    int         tests_failed;
    int         eval_seen;
    int         cycle_count;
    event       check_now;

    tb_clock_gen u_clock_gen (.clk(clk), .nRST(nRST));

    keypad_calc_top u_keypad_calc_top (
        .clk           (clk),
        .nRST          (nRST),
        .row_in        (row_in),
        .col_out       (col_out),
        .display_value (display_value),
        .result_valid  (result_valid)
    );

    // keypad matrix, row = code / 4 and column = code % 4
    assign row_in = (key_held && col_out[held_code[1:0]]) ?
                    (4'b0001 << held_code[3:2]) : 4'b0000;

    function automatic int rand_range(input int n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state >> 16) % n;
    endfunction

    function automatic int digit_of_key(input logic [3:0] code);
        int d;
        d = -1;                                 // not a digit key
        for (int i = 0; i < 10; i++)
            if (KEY_OF_DIGIT[i] == code)
                d = i;
        return d;
    endfunction

    // expected display after the first n keys of the history
    function automatic logic [DATA_W-1:0] ref_display(input int n);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [3:0]        op_key;
        calc_state_t       st;
        int                d;
        a = '0;
        b = '0;
        op_key = KEY_ADD;
        st = ENTER_A;
        for (int i = 0; i < n; i++) begin
            d = digit_of_key(key_hist[i]);
            if (d >= 0) begin
                if (st == SHOW) begin
                    a = '0;                     // fresh operand
                    st = ENTER_A;
                end
                if (st == ENTER_B)
                    b = b * 16'd10 + 16'(d);
                else
                    a = a * 16'd10 + 16'(d);
            end else if (key_hist[i] == KEY_EQUAL) begin
                if (st == ENTER_B) begin
                    case (op_key)
                        KEY_SUB: a = a - b;
                        KEY_MUL: a = a * b;     // low 16 bits only
                        default: a = a + b;
                    endcase
                    st = SHOW;
                end
            end else if (key_hist[i] == KEY_NEG) begin
                if (st == ENTER_B)
                    b = -b;
                else
                    a = -a;
            end else if (key_hist[i] != KEY_HASH && st != ENTER_B) begin
                op_key = key_hist[i];
                b = '0;
                st = ENTER_B;
            end
        end
        return (st == ENTER_B) ? b : a;
    endfunction

    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        assert (got === expected) else begin
            $display("Mismatch at %0t ns: %s = %0d, expected %0d", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic expect_display(input int expected);
        check_value("display_value", int'(display_value), expected);
    endtask

    task automatic hold_key(input logic [3:0] code, input int cycles);
        @(posedge clk);
        #1;
        held_code = code;
        key_held  = 1'b1;
        repeat (cycles) @(posedge clk);
        #1 key_held = 1'b0;
        repeat (CHECK_DELAY) @(posedge clk);
        #1 -> check_now;
        repeat (RELEASE_CYCLES - CHECK_DELAY) @(posedge clk);
    endtask

    task automatic press_key(input logic [3:0] code);
        key_hist[hist_len] = code;
        hist_len++;
        hold_key(code, HOLD_CYCLES);
    endtask

    task automatic random_sequence();
        int n_a;
        int n_b;
        int pick;
        n_a = 1 + rand_range(4);
        repeat (n_a) press_key(KEY_OF_DIGIT[rand_range(10)]);
        pick = rand_range(3);
        press_key(pick == 0 ? KEY_ADD : (pick == 1 ? KEY_SUB : KEY_MUL));
        n_b = 1 + rand_range(4);
        repeat (n_b) press_key(KEY_OF_DIGIT[rand_range(10)]);
        if (rand_range(4) == 0)
            press_key(KEY_NEG);
        press_key(KEY_EQUAL);
    endtask

    task automatic report_test(input int num, input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_mark);
            tests_failed++;
        end
    endtask

    // compares against the reference after each release
    always @(check_now) begin
        check_value("display_value", int'(display_value),
                    int'($signed(ref_display(hist_len))));
    end

    // and at every evaluation
    always @(posedge clk) begin
        if (nRST && result_valid) begin
            eval_seen++;
            check_value("display_value", int'(display_value),
                        int'($signed(ref_display(hist_len))));
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int err_mark;
        int eval_mark;
        key_held     = 1'b0;
        held_code    = 4'd0;
        hist_len     = 0;
        lcg_state    = 32'd18;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        eval_seen    = 0;
        cycle_count  = 0;

        err_mark = errors;
        repeat (2) @(posedge clk);
        #1;
        check_value("col_out", int'(col_out), 1);   // still in reset
        expect_display(0);
        check_value("result_valid", int'(result_valid), 0);
        @(posedge nRST);
        report_test(1, "reset state", err_mark);

        err_mark = errors;
        press_key(KEY_OF_DIGIT[4]);
        expect_display(4);
        press_key(KEY_OF_DIGIT[0]);
        expect_display(40);
        press_key(KEY_OF_DIGIT[7]);
        expect_display(407);
        report_test(2, "digit entry", err_mark);

        err_mark = errors;
        eval_mark = eval_seen;
        press_key(KEY_ADD);
        press_key(KEY_OF_DIGIT[2]);
        press_key(KEY_OF_DIGIT[5]);
        press_key(KEY_EQUAL);
        expect_display(432);
        press_key(KEY_SUB);
        press_key(KEY_OF_DIGIT[1]);
        repeat (3) press_key(KEY_OF_DIGIT[0]);
        press_key(KEY_EQUAL);
        expect_display(-568);
        press_key(KEY_MUL);
        press_key(KEY_OF_DIGIT[3]);
        repeat (2) press_key(KEY_OF_DIGIT[0]);
        press_key(KEY_EQUAL);
        expect_display(26208);                  // -170400 wrapped
        repeat (3) press_key(KEY_OF_DIGIT[9]);
        press_key(KEY_MUL);
        repeat (3) press_key(KEY_OF_DIGIT[9]);
        press_key(KEY_EQUAL);
        expect_display(14961);
        check_value("result_valid pulses", eval_seen - eval_mark, 4);
        report_test(3, "operators", err_mark);

        err_mark = errors;
        press_key(KEY_NEG);
        expect_display(-14961);
        press_key(KEY_OF_DIGIT[5]);
        expect_display(5);
        press_key(KEY_NEG);
        press_key(KEY_ADD);
        press_key(KEY_OF_DIGIT[1]);
        press_key(KEY_OF_DIGIT[2]);
        press_key(KEY_NEG);
        expect_display(-12);
        press_key(KEY_EQUAL);
        expect_display(-17);
        press_key(KEY_OF_DIGIT[3]);
        expect_display(3);
        report_test(4, "negate and fresh entry", err_mark);

        err_mark = errors;
        eval_mark = eval_seen;
        press_key(KEY_HASH);
        expect_display(3);
        hold_key(KEY_OF_DIGIT[9], GLITCH_CYCLES);   // too short to count
        expect_display(3);
        press_key(KEY_EQUAL);
        expect_display(3);
        check_value("result_valid pulses", eval_seen - eval_mark, 0);
        report_test(5, "ignored input", err_mark);

        err_mark = errors;
        repeat (20) random_sequence();
        report_test(6, "random sequences", err_mark);

        $display("summary: 6 tests, %0d failed, %0d checks, %0d errors",
                 tests_failed, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
